// File: Bender.yml
package:
  name: l2_cache

export_include_dirs:
  - .

sources:
  - l2_cache_pkg.sv
  - l2_cache_way.sv
  - l2_way_merge.sv
  - l2_cache_control.sv
  - l2_cache.sv
  - target: test
    files:
      - tb_l2_cache.sv

// File: l2_cache.f
+incdir+.
l2_cache_pkg.sv
l2_cache_way.sv
l2_way_merge.sv
l2_cache_control.sv
l2_cache.sv
tb_l2_cache.sv

// File: l2_cache.sv
`timescale 1ns/1ps
`include "l2_cache_cfg.svh"

module l2_cache
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input l2_cache_pkg::l2_addr_u mem_address,
	input logic [`L2_LINE_W-1:0] mem_wdata,
	input logic pmem_resp,
	input logic [`L2_LINE_W-1:0] pmem_rdata,
	output logic mem_resp,
	output logic [`L2_LINE_W-1:0] mem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output l2_cache_pkg::l2_addr_u pmem_address,
	output logic [`L2_LINE_W-1:0] pmem_wdata,
	output logic [31:0] miss_count
);

	import l2_cache_pkg::*;

	localparam int OFF_W = `L2_ADDR_W - `L2_TAG_W - `L2_SET_BITS;

	l2_addr_u addr_reg;

	logic addr_reg_load;
	logic write_enable;
	logic valid_in;
	logic dirty_datain;
	logic datain_mux_sel;
	logic cache_allocate;
	logic pmem_address_sel;
	logic cache_hit;
	logic dirtyout;

	logic hit0;
	logic hit1;
	logic dirty0;
	logic dirty1;
	logic we0;
	logic we1;
	logic [`L2_TAG_W-1:0] tag0;
	logic [`L2_TAG_W-1:0] tag1;
	logic [`L2_TAG_W-1:0] victim_tag;
	logic [`L2_LINE_W-1:0] rdata0;
	logic [`L2_LINE_W-1:0] rdata1;
	logic [`L2_LINE_W-1:0] line_rdata;
	logic [`L2_LINE_W-1:0] line_wdata;

	// The request address is held for the whole miss sequence.
	always_ff @(posedge clk)
	begin
		if (addr_reg_load)
			addr_reg <= mem_address;
	end

	// Requester data on a write hit, memory data on a refill.
	assign line_wdata = datain_mux_sel ? mem_wdata : pmem_rdata;

	// Write-back goes to the victim's line, refill to the request's line.
	assign pmem_address.raw = pmem_address_sel ?
		{victim_tag, addr_reg.fld.index, {OFF_W{1'b0}}} :
		{addr_reg.fld.tag, addr_reg.fld.index, {OFF_W{1'b0}}};

	assign pmem_wdata = line_rdata;
	assign mem_rdata = line_rdata;

	l2_cache_way way0 (
		.clk(clk), .rst_n(rst_n), .addr(addr_reg),
		.we(we0), .valid_in(valid_in), .dirty_in(dirty_datain),
		.tag_load(cache_allocate), .wdata(line_wdata),
		.hit(hit0), .dirty(dirty0), .tag(tag0), .rdata(rdata0)
	);

	l2_cache_way way1 (
		.clk(clk), .rst_n(rst_n), .addr(addr_reg),
		.we(we1), .valid_in(valid_in), .dirty_in(dirty_datain),
		.tag_load(cache_allocate), .wdata(line_wdata),
		.hit(hit1), .dirty(dirty1), .tag(tag1), .rdata(rdata1)
	);

	l2_way_merge merge (
		.clk(clk), .rst_n(rst_n), .index(addr_reg.fld.index),
		.hit0(hit0), .hit1(hit1), .dirty0(dirty0), .dirty1(dirty1),
		.tag0(tag0), .tag1(tag1), .rdata0(rdata0), .rdata1(rdata1),
		.write_enable(write_enable), .mem_resp(mem_resp),
		.cache_hit(cache_hit), .dirtyout(dirtyout), .rdata(line_rdata),
		.victim_tag(victim_tag), .we0(we0), .we1(we1)
	);

	l2_cache_control control (
		.clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
		.pmem_resp(pmem_resp), .cache_hit(cache_hit), .dirtyout(dirtyout),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .mem_resp(mem_resp),
		.datain_mux_sel(datain_mux_sel), .write_enable(write_enable),
		.valid_in(valid_in), .cache_allocate(cache_allocate),
		.dirty_datain(dirty_datain), .pmem_address_sel(pmem_address_sel),
		.addr_reg_load(addr_reg_load), .miss_count(miss_count)
	);

endmodule

// File: l2_cache_cfg.svh
`ifndef L2_CACHE_CFG_SVH
`define L2_CACHE_CFG_SVH

// ==============================
// Cache geometry
// ==============================

// Byte address width.
`define L2_ADDR_W 32

// Line width in bits, which makes a 32-byte line and a 5-bit offset.
`define L2_LINE_W 256

// Index width, giving 16 sets per way.
`define L2_SET_BITS 4

// Tag is whatever is left above the index and the offset.
`define L2_TAG_W 23

`endif

// File: l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic cache_hit,
	input logic dirtyout,
	output logic pmem_read,
	output logic pmem_write,
	output logic mem_resp,
	output logic datain_mux_sel,
	output logic write_enable,
	output logic valid_in,
	output logic cache_allocate,
	output logic dirty_datain,
	output logic pmem_address_sel,
	output logic addr_reg_load,
	output logic [31:0] miss_count
);

	import l2_cache_pkg::*;

	l2_state_e state;
	l2_state_e next_state;

	// ==============================
	// State outputs
	// ==============================

	always_comb
	begin
		datain_mux_sel = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		write_enable = 1'b0;
		valid_in = 1'b0;
		mem_resp = 1'b0;
		cache_allocate = 1'b0;
		dirty_datain = 1'b0;
		pmem_address_sel = 1'b0;

		unique case (state)
			HIT_1:
			begin
				if (cache_hit)
				begin
					if (mem_read)
					begin
						dirty_datain = dirtyout;
					end
					else if (mem_write)
					begin
						// A write hit replaces the whole line and marks it dirty.
						write_enable = 1'b1;
						valid_in = 1'b1;
						datain_mux_sel = 1'b1;
						dirty_datain = 1'b1;
					end
					mem_resp = 1'b1;
				end
			end
			EVICT:
			begin
				// Victim address and line go out until memory takes them.
				pmem_address_sel = 1'b1;
				pmem_write = 1'b1;
			end
			ALLOCATE:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					write_enable = 1'b1;
					valid_in = 1'b1;
					cache_allocate = 1'b1;
				end
			end
			default:
			begin
			end
		endcase
	end

	// ==============================
	// Next state
	// ==============================

	always_comb
	begin
		next_state = state;
		addr_reg_load = 1'b0;

		case (state)
			HIT:
			begin
				addr_reg_load = 1'b1;
				if (mem_read | mem_write)
				begin
					next_state = HIT_1;
				end
			end
			HIT_1:
			begin
				// No response here means the lookup missed.
				if (mem_resp)
					next_state = HIT;
				else if (dirtyout)
					next_state = EVICT;
				else
					next_state = ALLOCATE;
			end
			EVICT:
			begin
				if (pmem_resp)
					next_state = ALLOCATE;
			end
			ALLOCATE:
			begin
				if (pmem_resp)
					next_state = HIT;
			end
			default:
			begin
			end
		endcase
	end

	// Entering ALLOCATE happens exactly once per miss.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= HIT;
			miss_count <= '0;
		end
		else
		begin
			state <= next_state;
			if ((next_state == ALLOCATE) && (state != ALLOCATE))
				miss_count <= miss_count + 32'd1;
		end
	end

endmodule

// File: l2_cache_pkg.sv
`include "l2_cache_cfg.svh"

package l2_cache_pkg;

	// ==============================
	// Address word
	// ==============================

	// One address word, read either whole or split into tag, index and offset.
	typedef union packed
	{
		logic [`L2_ADDR_W-1:0] raw;
		struct packed
		{
			logic [`L2_TAG_W-1:0] tag;
			logic [`L2_SET_BITS-1:0] index;
			logic [`L2_ADDR_W-`L2_TAG_W-`L2_SET_BITS-1:0] offset;
		} fld;
	} l2_addr_u;

	// ==============================
	// Controller states
	// ==============================

	// HIT waits for a request, HIT_1 checks the tags.
	typedef enum logic [1:0]
	{
		HIT,
		HIT_1,
		EVICT,
		ALLOCATE
	} l2_state_e;

endpackage

// File: l2_cache_way.sv
`timescale 1ns/1ps
`include "l2_cache_cfg.svh"

module l2_cache_way
(
	input logic clk,
	input logic rst_n,
	input l2_cache_pkg::l2_addr_u addr,
	input logic we,
	input logic valid_in,
	input logic dirty_in,
	input logic tag_load,
	input logic [`L2_LINE_W-1:0] wdata,
	output logic hit,
	output logic dirty,
	output logic [`L2_TAG_W-1:0] tag,
	output logic [`L2_LINE_W-1:0] rdata
);

	import l2_cache_pkg::*;

	localparam int NSETS = 1 << `L2_SET_BITS;

	logic [`L2_TAG_W-1:0] tag_mem [NSETS];
	logic [`L2_LINE_W-1:0] line_mem [NSETS];
	logic [NSETS-1:0] valid_bits;
	logic [NSETS-1:0] dirty_bits;

	logic [`L2_SET_BITS-1:0] idx;

	assign idx = addr.fld.index;

	// ==============================
	// Lookup
	// ==============================

	// Reads are purely combinational on the indexed set.
	always_comb
	begin
		tag = tag_mem[idx];
		rdata = line_mem[idx];
		dirty = dirty_bits[idx];
		hit = valid_bits[idx] && (tag_mem[idx] == addr.fld.tag);
	end

	// ==============================
	// Update
	// ==============================

	// Valid and dirty bits of the indexed set follow each write.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (we)
		begin
			valid_bits[idx] <= valid_in;
			dirty_bits[idx] <= dirty_in;
		end
	end

	// The tag only changes when a new line is brought in.
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			line_mem[idx] <= wdata;
			if (tag_load)
			begin
				tag_mem[idx] <= addr.fld.tag;
			end
		end
	end

endmodule

// File: l2_way_merge.sv
`timescale 1ns/1ps
`include "l2_cache_cfg.svh"

module l2_way_merge
(
	input logic clk,
	input logic rst_n,
	input logic [`L2_SET_BITS-1:0] index,
	input logic hit0,
	input logic hit1,
	input logic dirty0,
	input logic dirty1,
	input logic [`L2_TAG_W-1:0] tag0,
	input logic [`L2_TAG_W-1:0] tag1,
	input logic [`L2_LINE_W-1:0] rdata0,
	input logic [`L2_LINE_W-1:0] rdata1,
	input logic write_enable,
	input logic mem_resp,
	output logic cache_hit,
	output logic dirtyout,
	output logic [`L2_LINE_W-1:0] rdata,
	output logic [`L2_TAG_W-1:0] victim_tag,
	output logic we0,
	output logic we1
);

	localparam int NSETS = 1 << `L2_SET_BITS;

	// One bit per set naming the most recently used way.
	logic [NSETS-1:0] mru_bits;

	logic victim;
	logic sel_way;

	// The victim is the way not marked as recently used.
	assign victim = ~mru_bits[index];

	assign cache_hit = hit0 | hit1;

	// On a hit everything follows the hit way, otherwise the victim.
	assign sel_way = cache_hit ? hit1 : victim;

	always_comb
	begin
		rdata = sel_way ? rdata1 : rdata0;
		dirtyout = sel_way ? dirty1 : dirty0;
		victim_tag = sel_way ? tag1 : tag0;
		we0 = write_enable & ~sel_way;
		we1 = write_enable & sel_way;
	end

	// Each response marks the way that served it.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mru_bits <= '0;
		end
		else if (mem_resp)
		begin
			mru_bits[index] <= sel_way;
		end
	end

endmodule

// File: tb_l2_cache.sv
`timescale 1ns/1ps
`include "l2_cache_cfg.svh"

module tb_l2_cache;

	import l2_cache_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 14;
	localparam int OP_LIMIT = 40;
	localparam int OFF_W = `L2_ADDR_W - `L2_TAG_W - `L2_SET_BITS;

	logic clk = 1'b0;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	l2_addr_u mem_address;
	logic [`L2_LINE_W-1:0] mem_wdata;
	logic pmem_resp;
	logic [`L2_LINE_W-1:0] pmem_rdata;
	logic mem_resp;
	logic [`L2_LINE_W-1:0] mem_rdata;
	logic pmem_read;
	logic pmem_write;
	l2_addr_u pmem_address;
	logic [`L2_LINE_W-1:0] pmem_wdata;
	logic [31:0] miss_count;
	l2_state_e ctrl_state;

	// Operation table, one row per test.
	logic op_write [NUM_TESTS];
	logic [31:0] op_addr [NUM_TESTS];
	logic [31:0] op_wseed [NUM_TESTS];
	logic [31:0] op_eseed [NUM_TESTS];
	int op_misses [NUM_TESTS];
	logic op_wb [NUM_TESTS];
	logic [31:0] op_wb_addr [NUM_TESTS];
	int op_rows = 0;

	logic [`L2_LINE_W-1:0] mem_lines [logic [31:0]];
	logic [`L2_LINE_W-1:0] shadow [logic [31:0]];
	logic [31:0] lfsr = 32'he26c8a5d;
	int mem_wait = 0;
	int reads_done = 0;
	int writes_done = 0;
	logic [31:0] last_wb_addr;
	logic [`L2_LINE_W-1:0] last_wb_line;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int total_misses = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	assign ctrl_state = UUT.control.state;

	l2_cache UUT (
		.clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
		.mem_address(mem_address), .mem_wdata(mem_wdata), .pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .miss_count(miss_count)
	);

	// ==============================
	// Helpers
	// ==============================

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] line_addr(input logic [31:0] a);
		return (a >> OFF_W) << OFF_W;
	endfunction

	// Untouched memory holds its own line address in every word.
	function automatic logic [`L2_LINE_W-1:0] init_line(input logic [31:0] a);
		logic [31:0] la;
		la = line_addr(a);
		return {(`L2_LINE_W / 32){la}};
	endfunction

	function automatic logic [`L2_LINE_W-1:0] make_line(input logic [31:0] seed);
		logic [`L2_LINE_W-1:0] line;
		int i;
		for (i = 0; i < `L2_LINE_W / 32; i++)
			line[i*32 +: 32] = seed + 32'h0101_0101 * i;
		return line;
	endfunction

	// Last line written to an address, else the initial pattern.
	function automatic logic [`L2_LINE_W-1:0] shadow_line(input logic [31:0] a);
		if (shadow.exists(line_addr(a)))
			return shadow[line_addr(a)];
		return init_line(a);
	endfunction

	task automatic check_value(input logic [`L2_LINE_W-1:0] got,
		input logic [`L2_LINE_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			pass_count++;
			$display("%s: ok", name);
		end
		else
		begin
			fail_count++;
			$display("%s: failed", name);
		end
	endtask

	task automatic add_entry(input logic w, input logic [31:0] addr, input logic [31:0] wseed,
		input logic [31:0] eseed, input int misses, input logic wb, input logic [31:0] wb_addr);
		op_write[op_rows] = w;
		op_addr[op_rows] = addr;
		op_wseed[op_rows] = wseed;
		op_eseed[op_rows] = eseed;
		op_misses[op_rows] = misses;
		op_wb[op_rows] = wb;
		op_wb_addr[op_rows] = wb_addr;
		op_rows++;
	endtask

	// Set 3 holds lines 0x060, 0x260 and 0x460, so every third new line evicts.
	// An expected seed of zero means the initial memory pattern.
	task automatic load_table();
		add_entry(1'b0, 32'h0000_0060, 32'h0, 32'h0, 1, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_007C, 32'h0, 32'h0, 0, 1'b0, 32'h0);
		add_entry(1'b1, 32'h0000_0068, 32'hA5A5_0000, 32'h0, 0, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_0060, 32'h0, 32'hA5A5_0000, 0, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_0260, 32'h0, 32'h0, 1, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_0460, 32'h0, 32'h0, 1, 1'b1, 32'h0000_0060);
		add_entry(1'b0, 32'h0000_0060, 32'h0, 32'hA5A5_0000, 1, 1'b0, 32'h0);
		add_entry(1'b1, 32'h0000_1A40, 32'h3C3C_1000, 32'h0, 1, 1'b0, 32'h0);
		add_entry(1'b1, 32'h0000_0460, 32'h9F00_2000, 32'h0, 0, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_0260, 32'h0, 32'h0, 1, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_0060, 32'h0, 32'hA5A5_0000, 1, 1'b1, 32'h0000_0460);
		add_entry(1'b0, 32'h0000_0460, 32'h0, 32'h9F00_2000, 1, 1'b0, 32'h0);
		add_entry(1'b0, 32'h0000_1A44, 32'h0, 32'h3C3C_1000, 0, 1'b0, 32'h0);
		add_entry(1'b0, 32'hFFFF_FE1F, 32'h0, 32'h0, 1, 1'b0, 32'h0);
	endtask

	task automatic run_entry(input int n);
		logic [31:0] miss_before;
		int reads_before;
		int writes_before;
		int errors_before;
		int cycles;
		logic [`L2_LINE_W-1:0] got;
		miss_before = miss_count;
		reads_before = reads_done;
		writes_before = writes_done;
		errors_before = error_count;
		mem_address.raw = op_addr[n];
		mem_wdata = op_write[n] ? make_line(op_wseed[n]) : '0;
		mem_read = !op_write[n];
		mem_write = op_write[n];
		cycles = 0;
		@(negedge clk);
		while (!mem_resp && cycles < OP_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		got = mem_rdata;
		if (!mem_resp)
		begin
			$display("Test %0d got no response within %0d cycles, controller stuck in %s",
				n, OP_LIMIT, ctrl_state.name());
			error_count++;
		end
		else if (!op_write[n])
			check_value(got, (op_eseed[n] == 0) ? init_line(op_addr[n]) :
				make_line(op_eseed[n]), "read data");
		else
			shadow[line_addr(op_addr[n])] = make_line(op_wseed[n]);
		// A hit answers in the cycle right after the request is sampled.
		if (mem_resp && op_misses[n] == 0)
			check_value(cycles, 0, "hit latency in extra cycles");
		// The request stays up through the edge that takes the response.
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
		total_misses += op_misses[n];
		check_value(miss_count - miss_before, op_misses[n], "miss count step");
		check_value(miss_count, total_misses, "miss count total");
		check_value(reads_done - reads_before, op_misses[n], "memory reads");
		check_value(writes_done - writes_before, op_wb[n], "write-backs");
		if (op_wb[n])
		begin
			check_value(last_wb_addr, op_wb_addr[n], "write-back address");
			check_value(last_wb_line, shadow_line(op_wb_addr[n]), "write-back line");
		end
		report_test($sformatf("test %0d %s %08h", n, op_write[n] ? "write" : "read",
			op_addr[n]), errors_before);
	endtask

	// ==============================
	// Memory model
	// ==============================

	initial
	begin
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever
		begin
			@(negedge clk);
			pmem_resp = 1'b0;
			if (!rst_n)
				mem_wait = 0;
			else if (pmem_read || pmem_write)
			begin
				// Latency of 1 to 4 cycles from two fresh LFSR bits.
				if (mem_wait == 0)
				begin
					lfsr = lfsr_step(lfsr);
					mem_wait = 1 + 2 * lfsr[0];
					lfsr = lfsr_step(lfsr);
					mem_wait = mem_wait + lfsr[0];
				end
				mem_wait--;
				if (mem_wait == 0)
				begin
					if (pmem_write)
					begin
						mem_lines[pmem_address.raw] = pmem_wdata;
						last_wb_addr = pmem_address.raw;
						last_wb_line = pmem_wdata;
						writes_done++;
					end
					else
					begin
						pmem_rdata = mem_lines.exists(pmem_address.raw) ?
							mem_lines[pmem_address.raw] : init_line(pmem_address.raw);
						reads_done++;
					end
					pmem_resp = 1'b1;
				end
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		int errors_before;
		int n;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		load_table();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		errors_before = error_count;
		check_value(mem_resp, 1'b0, "mem_resp after reset");
		check_value(pmem_read, 1'b0, "pmem_read after reset");
		check_value(pmem_write, 1'b0, "pmem_write after reset");
		check_value(miss_count, 32'd0, "miss_count after reset");
		report_test("reset", errors_before);
		for (n = 0; n < op_rows; n++)
			run_entry(n);
		$display("tests %0d, passed %0d, failed %0d, mismatches %0d",
			pass_count + fail_count, pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Forty cycles for every table row, plus the reset.
	initial
	begin
		#((NUM_TESTS * OP_LIMIT + RESET_CYCLES + 4) * CLK_PERIOD);
		$display("Timeout: the run did not complete in time, controller in state %s",
			ctrl_state.name());
		$display("=== FAIL ===");
		$finish;
	end

endmodule
